//--- project.f
src/uart_reg_pkg.sv
src/access_arbiter.sv
src/axil_write_channel.sv
src/axil_read_channel.sv
src/register_file.sv
src/uart_reg_block.sv
tb/tb_uart_reg_block.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_uart_reg_block
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module "$TOP" -f project.f -o "V$TOP"; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./obj_dir/V$TOP" > "$LOG" 2>&1; then
    echo "Simulation returned a failing status"
fi
cat "$LOG"

if grep -q "All tests passed!" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- src/access_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module access_arbiter (
    input  wire  clk,
    input  wire  rst,
    input  wire  wr_req,
    input  wire  rd_req,
    input  wire  wr_done,
    input  wire  rd_done,
    output logic wr_gnt,
    output logic rd_gnt
);

    logic locked;     // One transaction owns the register file
    logic owner_wr;   // Owner of the lock, 1 for the write side
    logic owner_done;

    // Free arbiter grants at once, write side first
    always_comb begin
        if (locked) begin
            wr_gnt = owner_wr;
            rd_gnt = !owner_wr;
        end else begin
            wr_gnt = wr_req;
            rd_gnt = rd_req && !wr_req;
        end
    end

    assign owner_done = owner_wr ? wr_done : rd_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked   <= 1'b0;
            owner_wr <= 1'b0;
        end else if (!locked) begin
            if (wr_req || rd_req) begin
                locked   <= 1'b1;
                owner_wr <= wr_req;
            end
        end else if (owner_done) begin
            locked <= 1'b0;   // Free again in the cycle after the response handshake
        end
    end

endmodule

`default_nettype wire

//--- src/axil_read_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axil_read_channel #(
    parameter int ADDR_WIDTH = 32
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      arvalid,
    output logic                                     arready,
    input  wire  [ADDR_WIDTH-1:0]                    araddr,
    output logic                                     rvalid,
    input  wire                                      rready,
    output logic [uart_reg_pkg::DATA_WIDTH-1:0]      rdata,
    output logic [1:0]                               rresp,
    output logic                                     rd_req,
    input  wire                                      rd_gnt,
    output logic                                     rd_done,
    output logic [uart_reg_pkg::OFFSET_WIDTH-1:0]    rd_offset,
    input  wire  [uart_reg_pkg::DATA_WIDTH-1:0]      rd_data
);

    typedef enum logic {
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    rd_state_t state;
    logic [uart_reg_pkg::OFFSET_WIDTH-1:0] addr_q;
    logic                                  ar_hs;
    logic                                  access_ok;

    assign rd_req  = (state == RD_ADDR) && arvalid;
    assign arready = (state == RD_ADDR) && rd_gnt;
    assign rvalid  = (state == RD_DATA);
    assign ar_hs   = arvalid && arready;
    assign rd_done = rvalid && rready;

    // Address stays latched for the whole data phase, so rdata holds under back-pressure
    assign rd_offset = addr_q;
    assign access_ok = uart_reg_pkg::read_access_ok(addr_q);
    assign rresp     = access_ok ? uart_reg_pkg::RESP_OKAY : uart_reg_pkg::RESP_SLVERR;
    assign rdata     = access_ok ? rd_data : '0;   // Errors return zero

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_ADDR;
        end else begin
            case (state)
                RD_ADDR: if (ar_hs)  state <= RD_DATA;
                RD_DATA: if (rready) state <= RD_ADDR;
                default: state <= RD_ADDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= araddr[uart_reg_pkg::OFFSET_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

//--- src/axil_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axil_write_channel #(
    parameter int ADDR_WIDTH = 32
) (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      awvalid,
    output logic                                     awready,
    input  wire  [ADDR_WIDTH-1:0]                    awaddr,
    input  wire                                      wvalid,
    output logic                                     wready,
    input  wire  [uart_reg_pkg::DATA_WIDTH-1:0]      wdata,
    input  wire  [uart_reg_pkg::STRB_WIDTH-1:0]      wstrb,
    output logic                                     bvalid,
    input  wire                                      bready,
    output logic [1:0]                               bresp,
    output logic                                     wr_req,
    input  wire                                      wr_gnt,
    output logic                                     wr_done,
    output logic                                     wr_en,
    output logic [uart_reg_pkg::OFFSET_WIDTH-1:0]    wr_offset,
    output logic [uart_reg_pkg::DATA_WIDTH-1:0]      wr_data,
    output logic [uart_reg_pkg::STRB_WIDTH-1:0]      wr_strb
);

    typedef enum logic [1:0] {
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    wr_state_t state;
    logic [uart_reg_pkg::OFFSET_WIDTH-1:0] addr_q;   // Latched at the AW handshake
    logic [1:0]                            bresp_q;
    logic                                  aw_hs;
    logic                                  w_hs;
    logic                                  access_ok;

    assign wr_req  = (state == WR_ADDR) && awvalid;
    assign awready = (state == WR_ADDR) && wr_gnt;
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);
    assign bresp   = bresp_q;

    assign aw_hs     = awvalid && awready;
    assign w_hs      = wvalid && wready;
    assign access_ok = uart_reg_pkg::write_access_ok(addr_q, wstrb);

    // Register file sees the beat only if the access rules allow it
    assign wr_en     = w_hs && access_ok;
    assign wr_offset = addr_q;
    assign wr_data   = wdata;
    assign wr_strb   = wstrb;
    assign wr_done   = bvalid && bready;   // Releases the arbiter

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= WR_ADDR;
            bresp_q <= uart_reg_pkg::RESP_OKAY;
        end else begin
            case (state)
                WR_ADDR: begin
                    if (aw_hs) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_hs) begin
                        state   <= WR_RESP;
                        bresp_q <= access_ok ? uart_reg_pkg::RESP_OKAY
                                             : uart_reg_pkg::RESP_SLVERR;
                    end
                end
                WR_RESP: begin
                    if (bready) begin
                        state <= WR_ADDR;
                    end
                end
                default: state <= WR_ADDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            addr_q <= awaddr[uart_reg_pkg::OFFSET_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      wr_en,
    input  wire  [uart_reg_pkg::OFFSET_WIDTH-1:0]    wr_offset,
    input  wire  [uart_reg_pkg::DATA_WIDTH-1:0]      wr_data,
    input  wire  [uart_reg_pkg::STRB_WIDTH-1:0]      wr_strb,
    input  wire  [uart_reg_pkg::OFFSET_WIDTH-1:0]    rd_offset,
    output logic [uart_reg_pkg::DATA_WIDTH-1:0]      rd_data,
    output logic                                     reset_stats,
    output logic [7:0]                               baud_div,
    output logic [7:0]                               timeout_cfg,
    output logic [3:0]                               debug_mode,
    input  wire                                      bridge_busy,
    input  wire  [7:0]                               error_code,
    input  wire  [15:0]                              tx_count,
    input  wire  [15:0]                              rx_count,
    input  wire  [7:0]                               fifo_status
);

    localparam int DW = uart_reg_pkg::DATA_WIDTH;
    localparam int OW = uart_reg_pkg::OFFSET_WIDTH;

    logic          ctrl_q;           // Bit 0 only
    logic [15:0]   cfg_q;            // Timeout in 15:8, baud divider in 7:0
    logic [3:0]    dbg_q;
    logic [DW-1:0] scratch_q [0:3];
    logic          reset_stats_q;

    logic [OW-1:0] wr_word;
    logic [OW-1:0] rd_word;
    logic [1:0]    wr_idx;
    logic [DW-1:0] ctrl_merge;
    logic [DW-1:0] cfg_merge;
    logic [DW-1:0] dbg_merge;
    logic [DW-1:0] scr_merge;
    logic          stats_hit;

    assign wr_word = {wr_offset[OW-1:2], 2'b00};
    assign rd_word = {rd_offset[OW-1:2], 2'b00};
    assign wr_idx  = wr_word[3:2];   // Scratch 0..3 at 0x020..0x02C

    // Strobed bytes replace the stored value, unused upper bits read as zero
    assign ctrl_merge = uart_reg_pkg::strobe_merge({{(DW-1){1'b0}}, ctrl_q}, wr_data, wr_strb);
    assign cfg_merge  = uart_reg_pkg::strobe_merge({{(DW-16){1'b0}}, cfg_q}, wr_data, wr_strb);
    assign dbg_merge  = uart_reg_pkg::strobe_merge({{(DW-4){1'b0}}, dbg_q}, wr_data, wr_strb);
    assign scr_merge  = uart_reg_pkg::strobe_merge(scratch_q[wr_idx], wr_data, wr_strb);

    // Bit 1 of control is a self-clearing command
    assign stats_hit = wr_en && (wr_word == uart_reg_pkg::REG_CONTROL)
                       && wr_strb[0] && wr_data[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q        <= 1'b0;
            cfg_q         <= '0;
            dbg_q         <= '0;
            reset_stats_q <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                scratch_q[i] <= '0;
            end
        end else begin
            reset_stats_q <= stats_hit;
            if (wr_en) begin
                case (wr_word)
                    uart_reg_pkg::REG_CONTROL: ctrl_q <= ctrl_merge[0];
                    uart_reg_pkg::REG_CONFIG:  cfg_q  <= cfg_merge[15:0];
                    uart_reg_pkg::REG_DEBUG:   dbg_q  <= dbg_merge[3:0];
                    uart_reg_pkg::REG_TEST_0,
                    uart_reg_pkg::REG_TEST_1,
                    uart_reg_pkg::REG_TEST_2,
                    uart_reg_pkg::REG_TEST_3: scratch_q[wr_idx] <= scr_merge;
                    default: ;   // Read-only targets ignore the data
                endcase
            end
        end
    end

    assign reset_stats = reset_stats_q;
    assign baud_div    = cfg_q[7:0];
    assign timeout_cfg = cfg_q[15:8];
    assign debug_mode  = dbg_q;

    always_comb begin
        rd_data = '0;
        case (rd_word)
            uart_reg_pkg::REG_CONTROL:   rd_data[0]    = ctrl_q;
            uart_reg_pkg::REG_STATUS:    rd_data[8:0]  = {error_code, bridge_busy};
            uart_reg_pkg::REG_CONFIG:    rd_data[15:0] = cfg_q;
            uart_reg_pkg::REG_DEBUG:     rd_data[3:0]  = dbg_q;
            uart_reg_pkg::REG_TX_COUNT:  rd_data[15:0] = tx_count;
            uart_reg_pkg::REG_RX_COUNT:  rd_data[15:0] = rx_count;
            uart_reg_pkg::REG_FIFO_STAT: rd_data[7:0]  = fifo_status;
            uart_reg_pkg::REG_VERSION:   rd_data       = uart_reg_pkg::VERSION_WORD;
            uart_reg_pkg::REG_TEST_0,
            uart_reg_pkg::REG_TEST_1,
            uart_reg_pkg::REG_TEST_2,
            uart_reg_pkg::REG_TEST_3:    rd_data       = scratch_q[rd_word[3:2]];
            default:                     rd_data       = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/uart_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module uart_reg_block #(
    parameter int ADDR_WIDTH = 32
) (
    input  wire                                      clk,
    input  wire                                      rst,
    // AXI4-Lite slave
    input  wire                                      awvalid,
    output logic                                     awready,
    input  wire  [ADDR_WIDTH-1:0]                    awaddr,
    input  wire                                      wvalid,
    output logic                                     wready,
    input  wire  [uart_reg_pkg::DATA_WIDTH-1:0]      wdata,
    input  wire  [uart_reg_pkg::STRB_WIDTH-1:0]      wstrb,
    output logic                                     bvalid,
    input  wire                                      bready,
    output logic [1:0]                               bresp,
    input  wire                                      arvalid,
    output logic                                     arready,
    input  wire  [ADDR_WIDTH-1:0]                    araddr,
    output logic                                     rvalid,
    input  wire                                      rready,
    output logic [uart_reg_pkg::DATA_WIDTH-1:0]      rdata,
    output logic [1:0]                               rresp,
    // Bridge side
    output logic                                     reset_stats,
    output logic [7:0]                               baud_div,
    output logic [7:0]                               timeout_cfg,
    output logic [3:0]                               debug_mode,
    input  wire                                      bridge_busy,
    input  wire  [7:0]                               error_code,
    input  wire  [15:0]                              tx_count,
    input  wire  [15:0]                              rx_count,
    input  wire  [7:0]                               fifo_status
);

    logic                                  wr_req;
    logic                                  rd_req;
    logic                                  wr_gnt;
    logic                                  rd_gnt;
    logic                                  wr_done;
    logic                                  rd_done;
    logic                                  wr_en;
    logic [uart_reg_pkg::OFFSET_WIDTH-1:0] wr_offset;
    logic [uart_reg_pkg::DATA_WIDTH-1:0]   wr_data;
    logic [uart_reg_pkg::STRB_WIDTH-1:0]   wr_strb;
    logic [uart_reg_pkg::OFFSET_WIDTH-1:0] rd_offset;
    logic [uart_reg_pkg::DATA_WIDTH-1:0]   rd_data;

    axil_write_channel #(.ADDR_WIDTH(ADDR_WIDTH)) wr_ch_i (
        .clk, .rst,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .wr_req, .wr_gnt, .wr_done,
        .wr_en, .wr_offset, .wr_data, .wr_strb
    );

    axil_read_channel #(.ADDR_WIDTH(ADDR_WIDTH)) rd_ch_i (
        .clk, .rst,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .rd_req, .rd_gnt, .rd_done,
        .rd_offset, .rd_data
    );

    // One transaction at a time, write wins a tie
    access_arbiter arb_i (
        .clk, .rst,
        .wr_req, .rd_req,
        .wr_done, .rd_done,
        .wr_gnt, .rd_gnt
    );

    register_file regs_i (
        .clk, .rst,
        .wr_en, .wr_offset, .wr_data, .wr_strb,
        .rd_offset, .rd_data,
        .reset_stats, .baud_div, .timeout_cfg, .debug_mode,
        .bridge_busy, .error_code, .tx_count, .rx_count, .fifo_status
    );

endmodule

`default_nettype wire

//--- src/uart_reg_pkg.sv
`default_nettype none

package uart_reg_pkg;

    localparam int DATA_WIDTH   = 32;
    localparam int STRB_WIDTH   = DATA_WIDTH / 8;
    localparam int OFFSET_WIDTH = 12;   // Only the low 12 address bits are decoded

    // Byte offsets of the register map
    localparam logic [OFFSET_WIDTH-1:0] REG_CONTROL   = 12'h000;
    localparam logic [OFFSET_WIDTH-1:0] REG_STATUS    = 12'h004;   // RO
    localparam logic [OFFSET_WIDTH-1:0] REG_CONFIG    = 12'h008;
    localparam logic [OFFSET_WIDTH-1:0] REG_DEBUG     = 12'h00C;
    localparam logic [OFFSET_WIDTH-1:0] REG_TX_COUNT  = 12'h010;   // RO
    localparam logic [OFFSET_WIDTH-1:0] REG_RX_COUNT  = 12'h014;   // RO
    localparam logic [OFFSET_WIDTH-1:0] REG_FIFO_STAT = 12'h018;   // RO
    localparam logic [OFFSET_WIDTH-1:0] REG_VERSION   = 12'h01C;   // RO
    localparam logic [OFFSET_WIDTH-1:0] REG_TEST_0    = 12'h020;
    localparam logic [OFFSET_WIDTH-1:0] REG_TEST_1    = 12'h024;
    localparam logic [OFFSET_WIDTH-1:0] REG_TEST_2    = 12'h028;
    localparam logic [OFFSET_WIDTH-1:0] REG_TEST_3    = 12'h02C;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [DATA_WIDTH-1:0] VERSION_WORD = 32'h0001_0000;   // Version 1.0

    function automatic logic offset_mapped(input logic [OFFSET_WIDTH-1:0] offset);
        logic [OFFSET_WIDTH-1:0] word;
        word = {offset[OFFSET_WIDTH-1:2], 2'b00};
        case (word)
            REG_CONTROL, REG_STATUS, REG_CONFIG, REG_DEBUG,
            REG_TX_COUNT, REG_RX_COUNT, REG_FIFO_STAT, REG_VERSION,
            REG_TEST_0, REG_TEST_1, REG_TEST_2, REG_TEST_3: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Byte, low half, high half or full word; anything else is refused
    function automatic logic write_access_ok(input logic [OFFSET_WIDTH-1:0] offset,
                                             input logic [STRB_WIDTH-1:0]   strb);
        if (!offset_mapped(offset)) begin
            return 1'b0;
        end
        case (strb)
            4'b0001, 4'b0011, 4'b1111: return (offset[1:0] == 2'b00);
            4'b1100:                   return (offset[1:0] == 2'b10);
            default:                   return 1'b0;
        endcase
    endfunction

    function automatic logic read_access_ok(input logic [OFFSET_WIDTH-1:0] offset);
        return offset_mapped(offset) && (offset[1:0] == 2'b00);
    endfunction

    function automatic logic [DATA_WIDTH-1:0] strobe_merge(input logic [DATA_WIDTH-1:0] old,
                                                           input logic [DATA_WIDTH-1:0] data,
                                                           input logic [STRB_WIDTH-1:0] strb);
        logic [DATA_WIDTH-1:0] merged;
        merged = old;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

//--- tb/tb_uart_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_reg_block;

    localparam int HALF           = 50;   // 100 ns clock
    localparam int QUARTER        = 25;   // Sample point after the falling edge
    localparam int TIMEOUT_CYCLES = 20;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic        clk;
    logic        rst;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        reset_stats;
    logic [7:0]  baud_div;
    logic [7:0]  timeout_cfg;
    logic [3:0]  debug_mode;
    logic        bridge_busy;
    logic [7:0]  error_code;
    logic [15:0] tx_count;
    logic [15:0] rx_count;
    logic [7:0]  fifo_status;

    logic [31:0] lcg_state = 32'h1456_f51c;
    string       test_name = "none";
    time         b_time;   // Sample time of the last B handshake
    time         r_time;   // Sample time of the last R handshake
    int          pulse_count = 0;

    uart_reg_block #(.ADDR_WIDTH(32)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    // Counts the cycles in which reset_stats is high
    always @(negedge clk) begin
        if (reset_stats) begin
            pulse_count <= pulse_count + 1;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("ERROR %s %s: expected 0x%08h, actual 0x%08h",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int hold_cycles,
                              output logic [1:0] resp);
        int cycles;
        int i;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        bready  = (hold_cycles == 0);
        cycles  = 0;
        #QUARTER;
        while (!awready) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) fail_run("Timeout while waiting for awready");
            @(negedge clk);
            #QUARTER;
        end
        @(negedge clk);
        awvalid = 1'b0;
        cycles  = 0;
        #QUARTER;
        while (!wready) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) fail_run("Timeout while waiting for wready");
            @(negedge clk);
            #QUARTER;
        end
        @(negedge clk);
        wvalid = 1'b0;
        cycles = 0;
        #QUARTER;
        while (!bvalid) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) fail_run("Timeout while waiting for bvalid");
            @(negedge clk);
            #QUARTER;
        end
        resp = bresp;
        // Response and lock must hold while the master stalls
        for (i = 0; i < hold_cycles; i++) begin
            @(negedge clk);
            bready = (i == hold_cycles - 1);
            #QUARTER;
            check_value("held bvalid", 32'd1, 32'(bvalid));
            check_value("held bresp", 32'(resp), 32'(bresp));
            check_value("arready during write response", 32'd0, 32'(arready));
        end
        b_time = $time;
        @(negedge clk);
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int cycles;
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        cycles  = 0;
        #QUARTER;
        while (!arready) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) fail_run("Timeout while waiting for arready");
            @(negedge clk);
            #QUARTER;
        end
        @(negedge clk);
        arvalid = 1'b0;
        cycles  = 0;
        #QUARTER;
        while (!rvalid) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) fail_run("Timeout while waiting for rvalid");
            @(negedge clk);
            #QUARTER;
        end
        data   = rdata;
        resp   = rresp;
        r_time = $time;
        @(negedge clk);
    endtask

    task automatic read_expect(input string what, input logic [31:0] addr,
                               input logic [31:0] exp_data, input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_value({what, " rresp"}, 32'(exp_resp), 32'(resp));
        check_value({what, " rdata"}, exp_data, data);
    endtask

    task automatic write_expect(input string what, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb,
                                input logic [1:0] exp_resp);
        logic [1:0] resp;
        axil_write(addr, data, strb, 0, resp);
        check_value({what, " bresp"}, 32'(exp_resp), 32'(resp));
    endtask

    task automatic test_reset_state();
        int i;
        test_name = "reset_state";
        #QUARTER;
        check_value("awready", 32'd0, 32'(awready));
        check_value("wready", 32'd0, 32'(wready));
        check_value("bvalid", 32'd0, 32'(bvalid));
        check_value("arready", 32'd0, 32'(arready));
        check_value("rvalid", 32'd0, 32'(rvalid));
        check_value("reset_stats", 32'd0, 32'(reset_stats));
        read_expect("control", 32'h000, 32'd0, OKAY);
        read_expect("config", 32'h008, 32'd0, OKAY);
        read_expect("debug", 32'h00C, 32'd0, OKAY);
        for (i = 0; i < 4; i++) begin
            read_expect("scratch", 32'h020 + 4 * i, 32'd0, OKAY);
        end
        read_expect("version", 32'h01C, 32'h0001_0000, OKAY);
        check_value("baud_div", 32'd0, 32'(baud_div));
        check_value("timeout_cfg", 32'd0, 32'(timeout_cfg));
        check_value("debug_mode", 32'd0, 32'(debug_mode));
    endtask

    task automatic test_full_words();
        logic [31:0] word;
        int i;
        test_name = "full_words";
        for (i = 0; i < 4; i++) begin
            word = next_rand();
            write_expect("scratch write", 32'h020 + 4 * i, word, 4'hF, OKAY);
            read_expect("scratch", 32'h020 + 4 * i, word, OKAY);
        end
        word = next_rand();
        write_expect("config write", 32'h008, word, 4'hF, OKAY);
        read_expect("config", 32'h008, {16'd0, word[15:0]}, OKAY);   // Only 16 bits stored
        check_value("baud_div", 32'(word[7:0]), 32'(baud_div));
        check_value("timeout_cfg", 32'(word[15:8]), 32'(timeout_cfg));
        word = next_rand();
        write_expect("debug write", 32'h00C, word, 4'hF, OKAY);
        check_value("debug_mode", 32'(word[3:0]), 32'(debug_mode));
    endtask

    task automatic test_strobes();
        logic [31:0] model;
        logic [31:0] word;
        test_name = "strobes";
        model = next_rand();
        write_expect("base write", 32'h024, model, 4'hF, OKAY);
        word = next_rand();
        write_expect("upper half", 32'h026, word, 4'b1100, OKAY);
        model = {word[31:16], model[15:0]};   // Upper lanes carry bytes 3 and 2
        read_expect("after upper half", 32'h024, model, OKAY);
        word = next_rand();
        write_expect("byte 0", 32'h024, word, 4'b0001, OKAY);
        model = {model[31:8], word[7:0]};
        read_expect("after byte 0", 32'h024, model, OKAY);
        write_expect("strobe 0101", 32'h024, next_rand(), 4'b0101, SLVERR);
        write_expect("misaligned word", 32'h025, next_rand(), 4'hF, SLVERR);
        write_expect("unmapped", 32'h030, next_rand(), 4'hF, SLVERR);
        read_expect("after refused writes", 32'h024, model, OKAY);
        write_expect("version write", 32'h01C, next_rand(), 4'hF, OKAY);
        read_expect("version", 32'h01C, 32'h0001_0000, OKAY);
    endtask

    task automatic test_status_reads();
        logic [31:0] word;
        logic [31:0] word2;
        test_name = "status_reads";
        word  = next_rand();
        word2 = next_rand();
        @(negedge clk);
        bridge_busy = 1'b1;
        error_code  = word[7:0];
        tx_count    = word[23:8];
        rx_count    = word2[15:0];
        fifo_status = word2[31:24];
        read_expect("status", 32'h004, {23'd0, word[7:0], 1'b1}, OKAY);
        read_expect("tx_count", 32'h010, {16'd0, word[23:8]}, OKAY);
        read_expect("rx_count", 32'h014, {16'd0, word2[15:0]}, OKAY);
        read_expect("fifo_status", 32'h018, {24'd0, word2[31:24]}, OKAY);
        read_expect("misaligned read", 32'h022, 32'd0, SLVERR);
        read_expect("unmapped read", 32'h040, 32'd0, SLVERR);
    endtask

    task automatic test_control();
        int start;
        test_name = "control";
        start = pulse_count;
        write_expect("stats reset write", 32'h000, 32'h3, 4'hF, OKAY);
        repeat (3) @(negedge clk);
        check_value("reset_stats cycles", 32'd1, 32'(pulse_count - start));
        read_expect("control", 32'h000, 32'h1, OKAY);   // Command bit reads back 0
        start = pulse_count;
        write_expect("empty strobe", 32'h000, 32'h2, 4'h0, SLVERR);
        repeat (3) @(negedge clk);
        check_value("reset_stats cycles", 32'd0, 32'(pulse_count - start));
    endtask

    task automatic test_arbitration();
        logic [31:0] word;
        logic [31:0] data;
        logic [1:0]  wresp;
        logic [1:0]  resp;
        int hold;
        test_name = "arbitration";
        // Second pass stalls the B channel for 5 cycles
        for (hold = 0; hold <= 5; hold += 5) begin
            word = next_rand();
            fork
                axil_write(32'h028, word, 4'hF, hold, wresp);
                axil_read(32'h028, data, resp);
            join
            check_value("bresp", 32'(OKAY), 32'(wresp));
            check_value("rresp", 32'(OKAY), 32'(resp));
            check_value("read after write", word, data);
            check_value("bvalid before rvalid", 32'd1, 32'(b_time < r_time));
        end
    endtask

    initial begin
        rst         = 1'b1;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        bready      = 1'b1;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b1;
        bridge_busy = 1'b0;
        error_code  = '0;
        tx_count    = '0;
        rx_count    = '0;
        fifo_status = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_full_words();
        test_strobes();
        test_status_reads();
        test_control();
        test_arbitration();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
